//--- src/core_pkg.sv
// RV32I subset ISA definitions.
// Holds the major opcodes, the ALU functions, the two views of the
// instruction word and the bundle that decode hands to execute.
`default_nettype none

package core_pkg;

    localparam int XLEN = 32; // one machine word.

    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011, // register-register ALU.
        OPC_OP_IMM = 7'b0010011, // register-immediate ALU.
        OPC_LUI    = 7'b0110111,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_PASS_B // forwards operand b, used by LUI.
    } alu_op_e;

    // register and immediate formats.
    typedef struct packed {
        logic [6:0] funct7; // also the upper immediate bits.
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        opcode_e    opcode;
    } r_i_t;

    // store and branch formats, where the immediate is split.
    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        opcode_e    opcode;
    } s_b_t;

    typedef union packed {
        r_i_t r_i;
        s_b_t s_b;
    } instr_u;

    typedef struct packed {
        alu_op_e          alu_op;
        logic             use_imm;   // operand b is the immediate.
        logic [XLEN-1:0]  imm;
        logic [4:0]       rs1;
        logic [4:0]       rs2;
        logic [4:0]       rd;
        logic             reg_we;
        logic             is_load;
        logic             is_store;
        logic             is_branch;
        logic             branch_ne; // BNE when set, BEQ otherwise.
        logic             is_jal;
    } dec_op_t;

endpackage

`default_nettype wire

//--- src/bus_pkg.sv
// Memory port definitions.
// One request word and one response word, shared by the fetch and data
// requesters, the arbiter and the external memory.
`default_nettype none

package bus_pkg;

    localparam int ADDR_W = 32; // byte address.
    localparam int DATA_W = 32; // one word per access.

    typedef struct packed {
        logic              valid; // a request is presented this cycle.
        logic              we;    // write when set, read otherwise.
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
    } mem_req_t;

    // read data answers the request of the previous cycle.
    typedef struct packed {
        logic [DATA_W-1:0] rdata;
    } mem_rsp_t;

endpackage

`default_nettype wire

//--- src/fetch_unit.sv
// Instruction fetch.
// Keeps the program counter and a FETCH/EXEC state, requests the word at
// pc and holds it in the instruction register until the instruction ends.
`timescale 1ns/1ps
`default_nettype none

module fetch_unit (
    input  logic                      clk,
    input  logic                      rst_n_i,
    input  logic                      stall_i,
    input  logic                      instr_done_i,
    input  logic                      redirect_i,
    input  logic [core_pkg::XLEN-1:0] redirect_pc_i,
    input  logic [core_pkg::XLEN-1:0] mem_rdata_i,
    output bus_pkg::mem_req_t         req_o,
    output core_pkg::instr_u          instr_o,
    output logic [core_pkg::XLEN-1:0] pc_o
);

    typedef enum logic {FETCH, EXEC} state_e;

    state_e                    state_q;
    logic [core_pkg::XLEN-1:0] pc_q;
    core_pkg::instr_u          ir_q;
    logic                      ir_valid_q; // the word has been captured.

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q    <= FETCH;
            pc_q       <= '0;
            ir_valid_q <= 1'b0;
        end else begin
            if (state_q == EXEC && !ir_valid_q) begin
                ir_valid_q <= 1'b1; // the word shows up in the first execute cycle.
            end
            if (!stall_i) begin
                if (state_q == FETCH) begin
                    state_q <= EXEC;
                end else if (instr_done_i) begin
                    state_q    <= FETCH;
                    pc_q       <= redirect_i ? redirect_pc_i : pc_q + 32'd4;
                    ir_valid_q <= 1'b0;
                end
            end
        end
    end

    // capture the word so that it survives stalls and the load data cycle.
    always_ff @(posedge clk) begin
        if (state_q == EXEC && !ir_valid_q) begin
            ir_q <= core_pkg::instr_u'(mem_rdata_i);
        end
    end

    always_comb begin
        req_o       = '0;
        req_o.valid = (state_q == FETCH); // the arbiter masks stalls.
        req_o.addr  = pc_q;
    end

    assign instr_o = ir_valid_q ? ir_q : core_pkg::instr_u'(mem_rdata_i);
    assign pc_o    = pc_q;

endmodule

`default_nettype wire

//--- src/decoder.sv
// Instruction decoder.
// Picks the format view from the opcode, builds the immediate and maps
// funct3 and funct7 to an ALU function. Unknown encodings become no-ops.
`timescale 1ns/1ps
`default_nettype none

module decoder (
    input  core_pkg::instr_u  instr_i,
    output core_pkg::dec_op_t dec_o
);

    logic                      is_sb;  // store or branch format.
    logic [2:0]                funct3;
    logic [core_pkg::XLEN-1:0] imm_i;
    logic [core_pkg::XLEN-1:0] imm_s;
    logic [core_pkg::XLEN-1:0] imm_b;
    logic [core_pkg::XLEN-1:0] imm_u;
    logic [core_pkg::XLEN-1:0] imm_j;

    assign is_sb  = instr_i.r_i.opcode inside {core_pkg::OPC_STORE, core_pkg::OPC_BRANCH};
    assign funct3 = instr_i.r_i.funct3; // same bits in both views.

    // ##############################
    // immediates
    // ##############################
    assign imm_i = {{20{instr_i.r_i.funct7[6]}}, instr_i.r_i.funct7, instr_i.r_i.rs2};
    assign imm_s = {{20{instr_i.s_b.imm_hi[6]}}, instr_i.s_b.imm_hi, instr_i.s_b.imm_lo};
    assign imm_b = {{19{instr_i.s_b.imm_hi[6]}}, instr_i.s_b.imm_hi[6], instr_i.s_b.imm_lo[0],
                    instr_i.s_b.imm_hi[5:0], instr_i.s_b.imm_lo[4:1], 1'b0};
    assign imm_u = {instr_i.r_i.funct7, instr_i.r_i.rs2, instr_i.r_i.rs1, funct3, 12'b0};
    assign imm_j = {{11{instr_i.r_i.funct7[6]}}, instr_i.r_i.funct7[6], instr_i.r_i.rs1,
                    funct3, instr_i.r_i.rs2[0], instr_i.r_i.funct7[5:0],
                    instr_i.r_i.rs2[4:1], 1'b0};

    // ##############################
    // control
    // ##############################
    always_comb begin
        dec_o     = '0;                                 // all flags low is a no-op.
        dec_o.rs1 = instr_i.r_i.rs1;
        dec_o.rs2 = instr_i.r_i.rs2;
        dec_o.rd  = is_sb ? 5'd0 : instr_i.r_i.rd;      // S/B formats have no rd.
        case (instr_i.r_i.opcode)
            core_pkg::OPC_OP: begin
                dec_o.reg_we = 1'b1;
                case (funct3)
                    3'b000:  dec_o.alu_op = instr_i.r_i.funct7[5] ? core_pkg::ALU_SUB
                                                                  : core_pkg::ALU_ADD;
                    3'b100:  dec_o.alu_op = core_pkg::ALU_XOR;
                    3'b110:  dec_o.alu_op = core_pkg::ALU_OR;
                    3'b111:  dec_o.alu_op = core_pkg::ALU_AND;
                    default: dec_o.reg_we = 1'b0;       // shifts and compares are not here.
                endcase
            end
            core_pkg::OPC_OP_IMM: begin
                dec_o.use_imm = 1'b1;
                dec_o.imm     = imm_i;
                dec_o.reg_we  = (funct3 == 3'b000);     // only ADDI is supported.
            end
            core_pkg::OPC_LUI: begin
                dec_o.alu_op  = core_pkg::ALU_PASS_B;
                dec_o.use_imm = 1'b1;
                dec_o.imm     = imm_u;
                dec_o.reg_we  = 1'b1;
            end
            core_pkg::OPC_LOAD: begin
                dec_o.use_imm = 1'b1;                   // address is rs1 plus imm.
                dec_o.imm     = imm_i;
                dec_o.reg_we  = 1'b1;
                dec_o.is_load = 1'b1;
            end
            core_pkg::OPC_STORE: begin
                dec_o.use_imm  = 1'b1;
                dec_o.imm      = imm_s;
                dec_o.is_store = 1'b1;
            end
            core_pkg::OPC_BRANCH: begin
                dec_o.imm       = imm_b;
                dec_o.is_branch = (funct3[2:1] == 2'b00); // BEQ and BNE only.
                dec_o.branch_ne = funct3[0];
            end
            core_pkg::OPC_JAL: begin
                dec_o.imm    = imm_j;
                dec_o.reg_we = 1'b1;
                dec_o.is_jal = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

//--- src/regbank.sv
// Integer register file.
// 32 words with two asynchronous read ports and one write port.
// Register x0 always reads as zero.
`timescale 1ns/1ps
`default_nettype none

module regbank (
    input  logic                      clk,
    input  logic                      rst_n_i,
    input  logic                      stall_i,
    input  logic [4:0]                rs1_i,
    input  logic [4:0]                rs2_i,
    input  logic [4:0]                rd_i,
    input  logic                      we_i,
    input  logic [core_pkg::XLEN-1:0] wdata_i,
    output logic [core_pkg::XLEN-1:0] rdata1_o,
    output logic [core_pkg::XLEN-1:0] rdata2_o
);

    logic [core_pkg::XLEN-1:0] regs [32];

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (!stall_i && we_i && rd_i != 5'd0) begin
            regs[rd_i] <= wdata_i; // writes to x0 are dropped here.
        end
    end

    assign rdata1_o = regs[rs1_i]; // x0 is never written, so it stays zero.
    assign rdata2_o = regs[rs2_i];

endmodule

`default_nettype wire

//--- src/execute_unit.sv
// Execute stage.
// ALU, branch compare, jump targets and the load/store request.
// Loads write back one cycle later, when the memory data returns.
`timescale 1ns/1ps
`default_nettype none

module execute_unit (
    input  logic                      clk,
    input  logic                      rst_n_i,
    input  logic                      stall_i,
    input  logic                      active_i,
    input  core_pkg::dec_op_t         dec_i,
    input  logic [core_pkg::XLEN-1:0] pc_i,
    input  logic [core_pkg::XLEN-1:0] op_a_i,
    input  logic [core_pkg::XLEN-1:0] op_b_i,
    input  logic [core_pkg::XLEN-1:0] mem_rdata_i,
    output bus_pkg::mem_req_t         data_req_o,
    output logic                      rf_we_o,
    output logic [4:0]                rf_rd_o,
    output logic [core_pkg::XLEN-1:0] rf_wdata_o,
    output logic                      redirect_o,
    output logic [core_pkg::XLEN-1:0] redirect_pc_o,
    output logic                      instr_done_o
);

    logic                      load_pend_q; // a load waits for its data.
    logic                      in_exec;     // first execute cycle.
    logic                      taken;
    logic [core_pkg::XLEN-1:0] opnd_b;
    logic [core_pkg::XLEN-1:0] alu_res;

    assign in_exec = active_i && !load_pend_q;
    assign opnd_b  = dec_i.use_imm ? dec_i.imm : op_b_i;

    always_comb begin
        case (dec_i.alu_op)
            core_pkg::ALU_ADD:    alu_res = op_a_i + opnd_b;
            core_pkg::ALU_SUB:    alu_res = op_a_i - opnd_b;
            core_pkg::ALU_AND:    alu_res = op_a_i & opnd_b;
            core_pkg::ALU_OR:     alu_res = op_a_i | opnd_b;
            core_pkg::ALU_XOR:    alu_res = op_a_i ^ opnd_b;
            core_pkg::ALU_PASS_B: alu_res = opnd_b;
            default:              alu_res = '0;
        endcase
    end

    // BNE inverts the equality test.
    assign taken         = dec_i.is_branch && ((op_a_i == op_b_i) ^ dec_i.branch_ne);
    assign redirect_o    = in_exec && (taken || dec_i.is_jal);
    assign redirect_pc_o = pc_i + dec_i.imm;

    always_comb begin
        data_req_o       = '0;
        data_req_o.valid = in_exec && (dec_i.is_load || dec_i.is_store);
        data_req_o.we    = dec_i.is_store;
        data_req_o.addr  = alu_res; // rs1 plus the immediate.
        data_req_o.wdata = op_b_i;
    end

    // loads retire in the data cycle, everything else right away.
    assign rf_we_o      = in_exec ? (dec_i.reg_we && !dec_i.is_load) : load_pend_q;
    assign rf_rd_o      = dec_i.rd;
    assign rf_wdata_o   = load_pend_q  ? mem_rdata_i :
                          dec_i.is_jal ? pc_i + 32'd4 : alu_res; // JAL links pc+4.
    assign instr_done_o = in_exec ? !dec_i.is_load : load_pend_q;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            load_pend_q <= 1'b0;
        end else if (!stall_i) begin
            load_pend_q <= in_exec && dec_i.is_load; // set only once the request went out.
        end
    end

endmodule

`default_nettype wire

//--- src/mem_arbiter.sv
// Memory port arbiter.
// Data requests win over fetch. The grant is remembered for one cycle so
// that the read data goes back to the side that asked for it.
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter (
    input  logic                       clk,
    input  logic                       rst_n_i,
    input  logic                       stall_i,
    input  bus_pkg::mem_req_t          ifetch_req_i,
    input  bus_pkg::mem_req_t          data_req_i,
    output bus_pkg::mem_req_t          mem_req_o,
    input  bus_pkg::mem_rsp_t          mem_rsp_i,
    output logic [bus_pkg::DATA_W-1:0] ifetch_rdata_o,
    output logic [bus_pkg::DATA_W-1:0] data_rdata_o
);

    logic gnt_data_q; // the data side owns the last issued access.

    always_comb begin
        mem_req_o = data_req_i.valid ? data_req_i : ifetch_req_i;
        if (stall_i) begin
            mem_req_o.valid = 1'b0; // nothing leaves the core while stalled.
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            gnt_data_q <= 1'b0;
        end else if (mem_req_o.valid) begin
            gnt_data_q <= data_req_i.valid;
        end
    end

    assign ifetch_rdata_o = gnt_data_q ? '0 : mem_rsp_i.rdata;
    assign data_rdata_o   = gnt_data_q ? mem_rsp_i.rdata : '0;

endmodule

`default_nettype wire

//--- src/rv_core_top.sv
// Top level of the multicycle RV32I subset core.
// Fetch, decode, register file and execute around one shared memory port.
`timescale 1ns/1ps
`default_nettype none

module rv_core_top (
    input  logic              clk,
    input  logic              rst_n_i,
    input  logic              stall_i,
    output bus_pkg::mem_req_t mem_req_o,
    input  bus_pkg::mem_rsp_t mem_rsp_i
);

    bus_pkg::mem_req_t         ifetch_req;
    bus_pkg::mem_req_t         data_req;
    logic [core_pkg::XLEN-1:0] ifetch_rdata;
    logic [core_pkg::XLEN-1:0] data_rdata;
    core_pkg::instr_u          instr;
    core_pkg::dec_op_t         dec;
    logic [core_pkg::XLEN-1:0] pc;
    logic [core_pkg::XLEN-1:0] op_a;
    logic [core_pkg::XLEN-1:0] op_b;
    logic                      rf_we;
    logic [4:0]                rf_rd;
    logic [core_pkg::XLEN-1:0] rf_wdata;
    logic                      redirect;
    logic [core_pkg::XLEN-1:0] redirect_pc;
    logic                      instr_done;

    // ##############################
    // front end
    // ##############################
    fetch_unit u_fetch (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .stall_i       (stall_i),
        .instr_done_i  (instr_done),
        .redirect_i    (redirect),
        .redirect_pc_i (redirect_pc),
        .mem_rdata_i   (ifetch_rdata),
        .req_o         (ifetch_req),
        .instr_o       (instr),
        .pc_o          (pc)
    );

    decoder u_decoder (
        .instr_i (instr),
        .dec_o   (dec)
    );

    regbank u_regbank (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .stall_i  (stall_i),
        .rs1_i    (dec.rs1),
        .rs2_i    (dec.rs2),
        .rd_i     (rf_rd),
        .we_i     (rf_we),
        .wdata_i  (rf_wdata),
        .rdata1_o (op_a),
        .rdata2_o (op_b)
    );

    // ##############################
    // execute and memory
    // ##############################
    execute_unit u_execute (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .stall_i       (stall_i),
        .active_i      (!ifetch_req.valid), // fetch requests only outside EXEC.
        .dec_i         (dec),
        .pc_i          (pc),
        .op_a_i        (op_a),
        .op_b_i        (op_b),
        .mem_rdata_i   (data_rdata),
        .data_req_o    (data_req),
        .rf_we_o       (rf_we),
        .rf_rd_o       (rf_rd),
        .rf_wdata_o    (rf_wdata),
        .redirect_o    (redirect),
        .redirect_pc_o (redirect_pc),
        .instr_done_o  (instr_done)
    );

    mem_arbiter u_arbiter (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .stall_i        (stall_i),
        .ifetch_req_i   (ifetch_req),
        .data_req_i     (data_req),
        .mem_req_o      (mem_req_o),
        .mem_rsp_i      (mem_rsp_i),
        .ifetch_rdata_o (ifetch_rdata),
        .data_rdata_o   (data_rdata)
    );

endmodule

`default_nettype wire

//--- verif/rv_core_tb.sv
// Testbench for the multicycle RV32I subset core.
// A synchronous memory model holds a fixed program, random stall pulses
// hold the core, and an instruction-set model predicts every memory request,
// its spacing in stall-free cycles and the value that each load writes back.
`timescale 1ns/1ps
`default_nettype none

module rv_core_tb;

    localparam int          PROG_LEN = 32;           // words in the program.
    localparam logic [31:0] FINAL_PC = 32'h0000_007c; // the closing self-loop.

    logic              clk;
    logic              rst_n_i;
    logic              stall_i;
    bus_pkg::mem_req_t mem_req_o;
    bus_pkg::mem_rsp_t mem_rsp_i;

    int seed = 88810; // stall pattern seed.

    logic [31:0] mem [256];     // memory seen by the core.
    logic [31:0] ref_mem [256]; // memory of the instruction-set model.
    logic [31:0] ref_regs [32];
    logic [31:0] ref_pc;

    bus_pkg::mem_req_t exp_data;   // data access of the instruction in flight.
    logic [31:0]       exp_load;
    logic              data_due;   // a data request comes next.
    logic              load_due;   // the load writes back in the next stall-free cycle.
    logic              fetch_seen;
    int                fetch_lat;  // 2 for most instructions, 3 for loads.
    int                fetch_idx;  // stall-free cycle of the last fetch.
    int                load_idx;
    int                act_idx;    // stall-free cycles since reset.
    int                cycle_cnt;
    int                stall_cnt;

    rv_core_top dut_i (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .stall_i   (stall_i),
        .mem_req_o (mem_req_o),
        .mem_rsp_i (mem_rsp_i)
    );

    // ##############################
    // instruction encoders
    // ##############################
    function automatic logic [31:0] r_type(input int f7, input int f3, input int rd,
                                           input int rs1, input int rs2);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'h33};
    endfunction

    function automatic logic [31:0] i_type(input int opc, input int f3, input int rd,
                                           input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc[6:0]};
    endfunction

    function automatic logic [31:0] s_type(input int rs2, input int rs1, input int off);
        return {off[11:5], rs2[4:0], rs1[4:0], 3'b010, off[4:0], 7'h23}; // SW only.
    endfunction

    function automatic logic [31:0] b_type(input int f3, input int rs1, input int rs2,
                                           input int off);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11], 7'h63};
    endfunction

    function automatic logic [31:0] u_type(input int rd, input int imm20);
        return {imm20[19:0], rd[4:0], 7'h37}; // LUI.
    endfunction

    function automatic logic [31:0] j_type(input int rd, input int off);
        return {off[20], off[10:1], off[11], off[19:12], rd[4:0], 7'h6f};
    endfunction

    // program image. Its data lives from byte 0x200 on.
    function automatic logic [31:0] program_word(input int idx);
        logic [31:0] word;
        case (idx)
            0:  word = u_type(1, 32'h12345);               // x1 = 0x12345000.
            1:  word = i_type(7'h13, 0, 1, 1, 32'h678);    // x1 = 0x12345678.
            2:  word = i_type(7'h13, 0, 2, 0, -16);        // x2 = 0xfffffff0.
            3:  word = r_type(0, 0, 3, 1, 2);              // add.
            4:  word = r_type(32, 0, 4, 1, 2);             // sub.
            5:  word = r_type(0, 7, 5, 1, 2);              // and.
            6:  word = r_type(0, 6, 6, 1, 2);              // or.
            7:  word = r_type(0, 4, 7, 1, 2);              // xor.
            8:  word = i_type(7'h13, 0, 8, 0, 32'h200);    // data base pointer.
            9:  word = s_type(3, 8, 0);
            10: word = s_type(4, 8, 4);
            11: word = s_type(5, 8, 8);
            12: word = s_type(6, 8, 12);
            13: word = s_type(7, 8, 16);
            14: word = i_type(7'h13, 0, 0, 1, 5);          // write to x0.
            15: word = s_type(0, 8, 20);                   // x0 must still be zero.
            16: word = i_type(7'h03, 2, 9, 8, 4);          // lw x9 gets the sub result.
            17: word = s_type(9, 8, 24);
            18: word = b_type(0, 1, 2, 8);                 // this beq is not taken.
            19: word = b_type(1, 1, 2, 8);                 // this bne is taken.
            20: word = i_type(7'h13, 0, 10, 0, 1);
            21: word = b_type(0, 9, 4, 8);                 // this beq is taken.
            22: word = i_type(7'h13, 0, 10, 0, 2);
            23: word = b_type(1, 9, 4, 8);                 // this bne is not taken.
            24: word = j_type(11, 8);                      // jal puts its link in x11.
            25: word = i_type(7'h13, 0, 10, 0, 3);
            26: word = s_type(11, 8, 28);
            27: word = s_type(10, 8, 32);                  // x10 stays zero if skips work.
            28: word = i_type(7'h03, 2, 12, 8, 28);
            29: word = r_type(0, 0, 13, 12, 9);            // reuses both loaded words.
            30: word = s_type(13, 8, 36);
            31: word = j_type(0, 0);                       // self-loop.
            default: word = {8'hee, idx[7:0], ~idx[7:0], idx[7:0]};
        endcase
        return word;
    endfunction

    // ##############################
    // instruction-set model
    // ##############################
    function automatic logic [31:0] iss_step(
        input  logic [31:0]       pc,
        output bus_pkg::mem_req_t data_req,
        output logic [31:0]       load_val,
        output int                lat
    );
        logic [31:0] w;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic [31:0] addr;
        logic [31:0] next_pc;
        logic        wr;
        w        = ref_mem[pc[9:2]];
        a        = ref_regs[w[19:15]];
        b        = ref_regs[w[24:20]];
        res      = '0;
        addr     = '0;
        next_pc  = pc + 32'd4;
        wr       = 1'b0;
        data_req = '0;
        load_val = '0;
        lat      = 2;
        case (w[6:0])
            7'h33: begin
                wr = 1'b1;
                case (w[14:12])
                    3'b000:  res = w[30] ? a - b : a + b;
                    3'b100:  res = a ^ b;
                    3'b110:  res = a | b;
                    3'b111:  res = a & b;
                    default: wr = 1'b0;
                endcase
            end
            7'h13: begin
                wr  = (w[14:12] == 3'b000);                  // ADDI only.
                res = a + {{20{w[31]}}, w[31:20]};
            end
            7'h37: begin
                wr  = 1'b1;
                res = {w[31:12], 12'b0};
            end
            7'h03: begin
                addr           = a + {{20{w[31]}}, w[31:20]};
                data_req.valid = 1'b1;
                data_req.addr  = addr;
                res            = ref_mem[addr[9:2]];
                load_val       = res;
                wr             = 1'b1;
                lat            = 3;                          // one more cycle for the data.
            end
            7'h23: begin
                addr              = a + {{20{w[31]}}, w[31:25], w[11:7]};
                data_req.valid    = 1'b1;
                data_req.we       = 1'b1;
                data_req.addr     = addr;
                data_req.wdata    = b;
                ref_mem[addr[9:2]] = b;
            end
            7'h63: begin
                if (w[14:13] == 2'b00 && ((a == b) != w[12])) begin
                    next_pc = pc + {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
                end
            end
            7'h6f: begin
                wr      = 1'b1;
                res     = pc + 32'd4;                        // link address.
                next_pc = pc + {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
            end
            default: ;                                       // anything else is a no-op.
        endcase
        if (wr && w[11:7] != 5'd0) begin
            ref_regs[w[11:7]] = res;
        end
        return next_pc;
    endfunction

    // ##############################
    // compare tasks
    // ##############################
    task automatic abort_run();
        $display("Simulation finished: FAIL");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_req(input string name, input bus_pkg::mem_req_t got,
                             input bus_pkg::mem_req_t exp);
        if (got.valid !== exp.valid || got.we !== exp.we || got.addr !== exp.addr) begin
            $display("Fail %s valid/we/addr: got %h/%h/%h, expected %h/%h/%h", name,
                     got.valid, got.we, got.addr, exp.valid, exp.we, exp.addr);
            abort_run();
        end
    endtask

    task automatic check_word(input string name, input logic [core_pkg::XLEN-1:0] got,
                              input logic [core_pkg::XLEN-1:0] exp);
        if (got !== exp) begin
            $display("Fail %s: got %h, expected %h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic measure_gap(input int from_idx, input int want);
        if (act_idx - from_idx != want) begin
            $display("request at cycle %0d came %0d stall-free cycles after the previous one, %s",
                     cycle_cnt, act_idx - from_idx, "which is the wrong spacing");
            abort_run();
        end
    endtask

    task automatic match_fetch();
        bus_pkg::mem_req_t exp;
        exp       = '0;
        exp.valid = 1'b1;
        exp.addr  = ref_pc;
        check_req("mem_req_o fetch", mem_req_o, exp);
        if (fetch_seen) begin
            measure_gap(fetch_idx, fetch_lat);
        end else begin
            measure_gap(0, 1);                               // first cycle after reset.
        end
    endtask

    task automatic verify_data_access();
        check_req("mem_req_o data", mem_req_o, exp_data);
        measure_gap(fetch_idx, 1);
        if (exp_data.we) begin
            check_word("mem_req_o.wdata", mem_req_o.wdata, exp_data.wdata);
        end else begin
            load_due = 1'b1;
            load_idx = act_idx;
        end
        data_due = 1'b0;
    endtask

    // ##############################
    // clock, reset and stimulus
    // ##############################
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        rst_n_i <= 1'b0;
        repeat (5) @(posedge clk);
        rst_n_i <= 1'b1;
    end

    // stall pulses start one cycle after reset is released.
    initial begin
        stall_i <= 1'b0;
        forever begin
            @(posedge clk);
            if (!rst_n_i) begin
                stall_i <= 1'b0;
            end else begin
                stall_i <= (($random(seed) & 7) == 0);       // about one cycle in eight.
            end
        end
    end

    // synchronous memory. Read data arrives one cycle after the request.
    initial begin
        mem_rsp_i <= '0;
        forever begin
            @(posedge clk);
            if (!rst_n_i) begin
                for (int i = 0; i < 256; i++) begin
                    mem[i] <= program_word(i);
                end
                mem_rsp_i.rdata <= '0;
            end else if (mem_req_o.valid) begin
                if (mem_req_o.we) begin
                    mem[mem_req_o.addr[9:2]] <= mem_req_o.wdata;
                end else begin
                    mem_rsp_i.rdata <= mem[mem_req_o.addr[9:2]]; // held while idle.
                end
            end
        end
    end

    // ##############################
    // comparison
    // ##############################
    always @(posedge clk) begin
        if (!rst_n_i) begin
            for (int i = 0; i < 32; i++) begin
                ref_regs[i] = '0;
            end
            for (int i = 0; i < 256; i++) begin
                ref_mem[i] = program_word(i);
            end
            ref_pc     = '0;
            exp_data   = '0;
            exp_load   = '0;
            data_due   = 1'b0;
            load_due   = 1'b0;
            fetch_seen = 1'b0;
            fetch_lat  = 0;
            fetch_idx  = 0;
            load_idx   = 0;
            act_idx    = 0;
            cycle_cnt  = 0;
            stall_cnt  = 0;
        end else begin
            cycle_cnt = cycle_cnt + 1;
            if (stall_i) begin
                stall_cnt = stall_cnt + 1;
            end
            if (cycle_cnt > 3 * PROG_LEN + stall_cnt + 50) begin
                $display("timeout after %0d cycles, the core did not reach the final loop",
                         cycle_cnt);
                abort_run();
            end else if (stall_i) begin
                if (mem_req_o.valid) begin
                    $display("a memory request left the core while stall_i was high");
                    abort_run();
                end
            end else begin
                act_idx = act_idx + 1;                       // counts stall-free cycles.
                if (load_due && act_idx == load_idx + 1) begin
                    check_word("dut_i.rf_wdata", dut_i.rf_wdata, exp_load);
                    load_due = 1'b0;
                end
                if (mem_req_o.valid && data_due) begin
                    verify_data_access();
                end else if (mem_req_o.valid && ref_pc == FINAL_PC) begin
                    match_fetch();
                    $display("Simulation finished: PASS");
                    $finish;
                end else if (mem_req_o.valid) begin
                    match_fetch();
                    fetch_idx  = act_idx;
                    fetch_seen = 1'b1;
                    ref_pc     = iss_step(ref_pc, exp_data, exp_load, fetch_lat);
                    data_due   = exp_data.valid;             // loads and stores go out next.
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- files.f
src/core_pkg.sv
src/bus_pkg.sv
src/fetch_unit.sv
src/decoder.sv
src/regbank.sv
src/execute_unit.sv
src/mem_arbiter.sv
src/rv_core_top.sv
verif/rv_core_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the core and its testbench with Verilator, runs it and checks the log.
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --timescale 1ns/1ps --top-module rv_core_tb \
    -f files.f -o Vrv_core_tb
./obj_dir/Vrv_core_tb | tee sim.log

if grep -q "Simulation finished: PASS" sim.log; then
    echo "run_sim: passed"
else
    echo "run_sim: failed"
    exit 1
fi
